/* pong_pkg.sv */
package pong_pkg;

        // ============================================================
        // screen geometry
        // ============================================================

        // size of the frame buffer in pixels
        localparam int screen_w = 160;
        localparam int screen_h = 120;

        // pixel coordinate widths on the frame buffer port
        localparam int x_bits = 8;
        localparam int y_bits = 7;

        // puck positions are 8.4 fixed point, the integer part is the pixel
        localparam int int_bits  = 8;
        localparam int frac_bits = 4;

        // the three border lines and the row the paddle lives on
        localparam int left_line  = 4;
        localparam int right_line = 155;
        localparam int top_line   = 8;
        localparam int paddle_row = 115;

        // ============================================================
        // colours, one bit each for red, green and blue
        // ============================================================

        localparam logic [2:0] black  = 3'b000;
        localparam logic [2:0] white  = 3'b111;
        localparam logic [2:0] cyan   = 3'b011;
        localparam logic [2:0] yellow = 3'b110;

        // a span walks along x (horizontal) or along y (vertical)
        typedef enum logic {
                span_h,
                span_v
        } span_dir_t;

endpackage

/* span_drawer.sv */
module span_drawer (
        input  logic                           CLOCK_50,
        input  logic                           KEY,
        input  logic                           span_req,
        input  logic [pong_pkg::x_bits-1:0]    span_x,
        input  logic [pong_pkg::y_bits-1:0]    span_y,
        input  logic [pong_pkg::x_bits-1:0]    span_len,
        input  pong_pkg::span_dir_t            span_dir,
        input  logic [2:0]                     span_colour,
        output logic                           span_ack,
        output logic [pong_pkg::x_bits-1:0]    x,
        output logic [pong_pkg::y_bits-1:0]    y,
        output logic [2:0]                     colour,
        output logic                           plot
);

        // pixels still to go after the one on the port right now
        logic [pong_pkg::x_bits-1:0] remaining;

        // high while a span is being emitted
        logic busy;

        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY) begin
                        busy      <= 1'b0;
                        plot      <= 1'b0;
                        span_ack  <= 1'b0;
                        remaining <= '0;
                        x         <= '0;
                        y         <= '0;
                        colour    <= pong_pkg::black;
                end else if (busy) begin
                        if (remaining == '0) begin
                                // last pixel is on the port, acknowledge on the next cycle
                                busy     <= 1'b0;
                                plot     <= 1'b0;
                                span_ack <= 1'b1;
                        end else begin
                                remaining <= remaining - 1'b1;
                                if (span_dir == pong_pkg::span_h)
                                        x <= x + 1'b1;
                                else
                                        y <= y + 1'b1;
                        end
                end else if (span_ack) begin
                        // wait for the sequencer to drop its request
                        if (!span_req)
                                span_ack <= 1'b0;
                end else if (span_req) begin
                        // first pixel goes out on the cycle after the request is seen
                        busy      <= 1'b1;
                        plot      <= 1'b1;
                        x         <= span_x;
                        y         <= span_y;
                        colour    <= span_colour;
                        remaining <= span_len - 1'b1;
                end
        end

endmodule

/* puck_physics.sv */
module puck_physics #(
        parameter int start_x      = 1280,
        parameter int start_y      = 960,
        parameter int vel_x        = 8,
        parameter int vel_y        = -12,
        parameter int paddle_width = 8
) (
        input  logic                           CLOCK_50,
        input  logic                           KEY,
        input  logic                           step,
        input  logic                           restart,
        input  logic [pong_pkg::x_bits-1:0]    paddle_x,
        output logic [pong_pkg::x_bits-1:0]    puck_x,
        output logic [pong_pkg::y_bits-1:0]    puck_y,
        output logic                           miss
);

        localparam int fb = pong_pkg::frac_bits;
        localparam int fp = pong_pkg::int_bits + pong_pkg::frac_bits;

        // rows a bouncing puck is pinned to, with the fraction cleared
        localparam logic [fp-1:0] top_stop = fp'((pong_pkg::top_line + 1) << fb);
        localparam logic [fp-1:0] pad_stop = fp'((pong_pkg::paddle_row - 1) << fb);

        logic [fp-1:0] pos_x, pos_y, vx, vy;
        logic [fp-1:0] nx, ny, nvx, nvy;
        logic          nmiss;

        // ============================================================
        // one move, computed from the current state
        // ============================================================

        always_comb begin
                nx    = pos_x + vx;
                ny    = pos_y + vy;
                nvx   = vx;
                nvy   = vy;
                nmiss = 1'b0;
                // bounce off the top line
                if (ny[fp-1:fb] <= pong_pkg::top_line + 1) begin
                        nvy = -vy;
                        ny  = top_stop;
                end
                // bounce off either side line
                if (nx[fp-1:fb] <= pong_pkg::left_line + 1 ||
                    nx[fp-1:fb] >= pong_pkg::right_line - 1)
                        nvx = -vx;
                // at the paddle row the puck either hits the paddle or is lost
                if (ny[fp-1:fb] >= pong_pkg::paddle_row - 1) begin
                        if (nx[fp-1:fb] >= paddle_x &&
                            nx[fp-1:fb] <= paddle_x + paddle_width) begin
                                nvy = -vy;
                                ny  = pad_stop;
                        end else begin
                                nmiss = 1'b1;
                        end
                end
        end

        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY || restart) begin
                        pos_x <= fp'(start_x);
                        pos_y <= fp'(start_y);
                        vx    <= fp'(vel_x);
                        vy    <= fp'(vel_y);
                        miss  <= 1'b0;
                end else if (step) begin
                        pos_x <= nx;
                        pos_y <= ny;
                        vx    <= nvx;
                        vy    <= nvy;
                        miss  <= nmiss;
                end
        end

        // the pixel is the integer part of the position
        assign puck_x = pos_x[fp-1:fb];
        assign puck_y = pos_y[fb +: pong_pkg::y_bits];

endmodule

/* paddle_ctrl.sv */
module paddle_ctrl #(
        parameter int paddle_width = 8,
        parameter int paddle_start = 76
) (
        input  logic                           CLOCK_50,
        input  logic                           KEY,
        input  logic                           move_right,
        input  logic                           move_left,
        input  logic                           paddle_step,
        input  logic                           restart,
        output logic [pong_pkg::x_bits-1:0]    paddle_x
);

        localparam int xw = pong_pkg::x_bits;

        // outermost positions that keep the paddle inside the side lines
        localparam logic [xw-1:0] max_x = xw'(pong_pkg::right_line - 1 - paddle_width);
        localparam logic [xw-1:0] min_x = xw'(pong_pkg::left_line + 1);

        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY || restart) begin
                        paddle_x <= xw'(paddle_start);
                end else if (paddle_step) begin
                        // keys are active low and right wins when both are held
                        if (!move_right) begin
                                if (paddle_x + 2 <= max_x)
                                        paddle_x <= paddle_x + 2'd2;
                                else
                                        paddle_x <= max_x;
                        end else if (!move_left) begin
                                if (paddle_x >= min_x + 2)
                                        paddle_x <= paddle_x - 2'd2;
                                else
                                        paddle_x <= min_x;
                        end
                end
        end

endmodule

/* frame_sequencer.sv */
module frame_sequencer #(
        parameter int loop_speed   = 6250000,
        parameter int paddle_width = 8
) (
        input  logic                           CLOCK_50,
        input  logic                           KEY,
        input  logic [pong_pkg::x_bits-1:0]    paddle_x,
        input  logic [pong_pkg::x_bits-1:0]    puck_x [2],
        input  logic [pong_pkg::y_bits-1:0]    puck_y [2],
        input  logic                           miss [2],
        input  logic                           span_ack,
        output logic                           span_req,
        output logic [pong_pkg::x_bits-1:0]    span_x,
        output logic [pong_pkg::y_bits-1:0]    span_y,
        output logic [pong_pkg::x_bits-1:0]    span_len,
        output pong_pkg::span_dir_t            span_dir,
        output logic [2:0]                     span_colour,
        output logic                           paddle_step,
        output logic                           puck_step [2],
        output logic                           restart
);

        localparam int xw = pong_pkg::x_bits;
        localparam int yw = pong_pkg::y_bits;
        localparam int cnt_bits = $clog2(loop_speed + 1);

        typedef enum logic [3:0] {
                s_clear, s_top, s_right, s_left, s_delay,
                s_pad_erase, s_pad_step, s_pad_draw,
                s_puck_erase, s_puck_step, s_puck_check, s_puck_draw,
                s_restart
        } state_t;

        state_t                state;
        logic [yw-1:0]         row;
        logic                  pk;
        logic [cnt_bits-1:0]   delay_cnt;
        logic                  draw_state;
        logic                  span_done;

        // ============================================================
        // span request fields decoded from the state
        // ============================================================

        // fields only change on a step pulse, never while a request is up
        always_comb begin
                draw_state  = 1'b1;
                span_x      = '0;
                span_y      = '0;
                span_len    = xw'(1);
                span_dir    = pong_pkg::span_h;
                span_colour = pong_pkg::white;
                case (state)
                        s_clear: begin
                                span_y      = row;
                                span_len    = xw'(pong_pkg::screen_w);
                                span_colour = pong_pkg::black;
                        end
                        s_top: begin
                                span_x   = xw'(pong_pkg::left_line);
                                span_y   = yw'(pong_pkg::top_line);
                                span_len = xw'(pong_pkg::right_line - pong_pkg::left_line + 1);
                        end
                        s_right, s_left: begin
                                span_x   = (state == s_right) ? xw'(pong_pkg::right_line)
                                                              : xw'(pong_pkg::left_line);
                                span_y   = yw'(pong_pkg::top_line);
                                span_len = xw'(pong_pkg::screen_h - pong_pkg::top_line);
                                span_dir = pong_pkg::span_v;
                        end
                        s_pad_erase, s_pad_draw: begin
                                // the paddle covers paddle_width plus one pixels
                                span_x      = paddle_x;
                                span_y      = yw'(pong_pkg::paddle_row);
                                span_len    = xw'(paddle_width + 1);
                                span_colour = (state == s_pad_draw) ? pong_pkg::white
                                                                    : pong_pkg::black;
                        end
                        s_puck_erase, s_puck_draw: begin
                                span_x = puck_x[pk];
                                span_y = puck_y[pk];
                                if (state == s_puck_erase)
                                        span_colour = pong_pkg::black;
                                else
                                        span_colour = pk ? pong_pkg::yellow : pong_pkg::cyan;
                        end
                        default: draw_state = 1'b0;
                endcase
        end

        // step and restart pulses last the single cycle spent in their state
        assign paddle_step  = (state == s_pad_step);
        assign puck_step[0] = (state == s_puck_step) && !pk;
        assign puck_step[1] = (state == s_puck_step) && pk;
        assign restart      = (state == s_restart);

        assign span_done = span_req && span_ack;

        // the four-phase request is raised again only once the drawer has dropped its ack
        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY)
                        span_req <= 1'b0;
                else if (span_done)
                        span_req <= 1'b0;
                else if (draw_state && !span_ack)
                        span_req <= 1'b1;
        end

        // ============================================================
        // game state machine
        // ============================================================

        always_ff @(posedge CLOCK_50 or negedge KEY) begin
                if (!KEY) begin
                        state     <= s_clear;
                        row       <= '0;
                        pk        <= 1'b0;
                        delay_cnt <= '0;
                end else begin
                        case (state)
                                s_clear: if (span_done) begin
                                        if (row == yw'(pong_pkg::screen_h - 1))
                                                state <= s_top;
                                        else
                                                row <= row + 1'b1;
                                end
                                s_top:   if (span_done) state <= s_right;
                                s_right: if (span_done) state <= s_left;
                                s_left:  if (span_done) state <= s_delay;
                                s_delay: begin
                                        // plot stays low here since no span is requested
                                        if (delay_cnt == cnt_bits'(loop_speed - 1)) begin
                                                delay_cnt <= '0;
                                                state     <= s_pad_erase;
                                        end else begin
                                                delay_cnt <= delay_cnt + 1'b1;
                                        end
                                end
                                s_pad_erase:  if (span_done) state <= s_pad_step;
                                s_pad_step:   state <= s_pad_draw;
                                s_pad_draw:   if (span_done) state <= s_puck_erase;
                                s_puck_erase: if (span_done) state <= s_puck_step;
                                s_puck_step:  state <= s_puck_check;
                                // miss is valid here in the cycle after the step
                                s_puck_check: state <= miss[pk] ? s_restart : s_puck_draw;
                                s_puck_draw: if (span_done) begin
                                        pk    <= ~pk;
                                        state <= pk ? s_delay : s_puck_erase;
                                end
                                default: begin
                                        // after a restart the game begins again with a full clear
                                        row   <= '0;
                                        pk    <= 1'b0;
                                        state <= s_clear;
                                end
                        endcase
                end
        end

endmodule

/* pong_top.sv */
module pong_top #(
        parameter int loop_speed   = 6250000,
        parameter int paddle_width = 8,
        parameter int paddle_start = 76
) (
        input  logic                           CLOCK_50,
        input  logic [3:0]                     KEY,
        output logic [pong_pkg::x_bits-1:0]    x,
        output logic [pong_pkg::y_bits-1:0]    y,
        output logic [2:0]                     colour,
        output logic                           plot
);

        logic                           span_req, span_ack;
        logic [pong_pkg::x_bits-1:0]    span_x, span_len, paddle_x;
        logic [pong_pkg::y_bits-1:0]    span_y;
        pong_pkg::span_dir_t            span_dir;
        logic [2:0]                     span_colour;
        logic                           paddle_step, restart;
        logic                           puck_step [2];
        logic                           miss [2];
        logic [pong_pkg::x_bits-1:0]    puck_x [2];
        logic [pong_pkg::y_bits-1:0]    puck_y [2];

        // KEY[3] is the reset, KEY[0] and KEY[1] move the paddle right and left
        frame_sequencer #(.loop_speed(loop_speed), .paddle_width(paddle_width)) u_seq (
                .CLOCK_50(CLOCK_50), .KEY(KEY[3]), .paddle_x(paddle_x),
                .puck_x(puck_x), .puck_y(puck_y), .miss(miss), .span_ack(span_ack),
                .span_req(span_req), .span_x(span_x), .span_y(span_y),
                .span_len(span_len), .span_dir(span_dir), .span_colour(span_colour),
                .paddle_step(paddle_step), .puck_step(puck_step), .restart(restart)
        );

        span_drawer u_draw (
                .CLOCK_50(CLOCK_50), .KEY(KEY[3]), .span_req(span_req),
                .span_x(span_x), .span_y(span_y), .span_len(span_len),
                .span_dir(span_dir), .span_colour(span_colour), .span_ack(span_ack),
                .x(x), .y(y), .colour(colour), .plot(plot)
        );

        paddle_ctrl #(.paddle_width(paddle_width), .paddle_start(paddle_start)) u_paddle (
                .CLOCK_50(CLOCK_50), .KEY(KEY[3]), .move_right(KEY[0]),
                .move_left(KEY[1]), .paddle_step(paddle_step), .restart(restart),
                .paddle_x(paddle_x)
        );

        // puck 0 starts mid screen heading up and right, in 8.4 fixed point
        puck_physics #(.start_x(1280), .start_y(960), .vel_x(8), .vel_y(-12),
                       .paddle_width(paddle_width)) u_puck0 (
                .CLOCK_50(CLOCK_50), .KEY(KEY[3]), .step(puck_step[0]),
                .restart(restart), .paddle_x(paddle_x), .puck_x(puck_x[0]),
                .puck_y(puck_y[0]), .miss(miss[0])
        );

        // puck 1 starts upper left heading down and left
        puck_physics #(.start_x(640), .start_y(640), .vel_x(-10), .vel_y(5),
                       .paddle_width(paddle_width)) u_puck1 (
                .CLOCK_50(CLOCK_50), .KEY(KEY[3]), .step(puck_step[1]),
                .restart(restart), .paddle_x(paddle_x), .puck_x(puck_x[1]),
                .puck_y(puck_y[1]), .miss(miss[1])
        );

endmodule

/* tb_clock.sv */
module tb_clock #(
        parameter int period       = 40,
        parameter int reset_cycles = 16
) (
        output logic CLOCK_50,
        output logic reset_n
);

        // free running clock, starts low at time zero
        initial begin
                CLOCK_50 = 1'b0;
                forever #(period / 2) CLOCK_50 = ~CLOCK_50;
        end

        // reset is held low for a fixed number of rising edges, then released on an edge
        initial begin
                reset_n = 1'b0;
                repeat (reset_cycles) @(posedge CLOCK_50);
                reset_n <= 1'b1;
        end

endmodule

/* tb_pong.sv */
module tb_pong;

        // paddle geometry from the game rules with the default width
        localparam int pad_w      = 8;
        localparam int pad_min    = pong_pkg::left_line + 1;
        localparam int pad_max    = pong_pkg::right_line - 1 - pad_w;
        localparam int speed      = 20;
        localparam int wait_limit = 2000;
        localparam int max_passes = 3000;

        logic                           CLOCK_50, reset_n;
        logic [1:0]                     keys;
        logic [pong_pkg::x_bits-1:0]    x;
        logic [pong_pkg::y_bits-1:0]    y;
        logic [2:0]                     colour;
        logic                           plot;

        logic [15:0] lfsr;
        int          errors, stop, idle, first_x, passes, test_base, tests, failed;
        int          m_pad, m_px [2], m_py [2], m_vx [2], m_vy [2];
        bit          m_miss;

        tb_clock #(.period(40), .reset_cycles(16)) u_clock (
                .CLOCK_50(CLOCK_50), .reset_n(reset_n)
        );

        // KEY[3] resets while KEY[1] moves left and KEY[0] moves right, and all are active low
        pong_top #(.loop_speed(speed)) i_dut (
                .CLOCK_50(CLOCK_50), .KEY({reset_n, 1'b1, keys}),
                .x(x), .y(y), .colour(colour), .plot(plot)
        );

        // ============================================================
        // random bits and result bookkeeping
        // ============================================================

        // 16 bit galois lfsr with taps 16, 14, 13 and 11
        function automatic logic [15:0] lfsr_step(input logic [15:0] s);
                return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
        endfunction

        task automatic take_bit(output logic b);
                b    = lfsr[0];
                lfsr = lfsr_step(lfsr);
        endtask

        task automatic compare(input string name, input int exp, input int got);
                if (got != exp) begin
                        errors++;
                        $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, got);
                end
                // a broken stream only repeats the same error so checking stops after many
                if (errors > 30 && stop == 0) begin
                        $display("too many mismatches, the run is stopped");
                        stop = 1;
                end
        endtask

        task automatic report(input string name);
                tests++;
                if (stop != 0 || errors != test_base) begin
                        failed++;
                        $display("FAIL %s (%0d errors)", name, errors - test_base);
                end else begin
                        $display("ok   %s", name);
                end
                test_base = errors;
        endtask

        // ============================================================
        // pixel stream checks on the falling edge
        // ============================================================

        // waits for the next plotted pixel and counts the idle cycles before it
        task automatic wait_plot();
                idle = 0;
                @(negedge CLOCK_50);
                while (!plot && idle < wait_limit) begin
                        idle++;
                        @(negedge CLOCK_50);
                end
                if (!plot) begin
                        $display("timeout, no pixel was plotted for %0d cycles", wait_limit);
                        stop = 1;
                end
        endtask

        // one run of pixels on consecutive cycles along x or down y
        task automatic expect_span(input int x0, input int y0, input int len, input bit vert,
                                   input int col);
                if (stop != 0)
                        return;
                wait_plot();
                if (stop != 0)
                        return;
                first_x = x;
                for (int i = 0; i < len; i++) begin
                        if (i > 0)
                                @(negedge CLOCK_50);
                        if (!plot) begin
                                errors++;
                                $display("span at %0d,%0d broke off after %0d pixels", x0, y0, i);
                                return;
                        end
                        compare("x", vert ? x0 : x0 + i, x);
                        compare("y", vert ? y0 + i : y0, y);
                        compare("colour", col, colour);
                end
        endtask

        task automatic check_screen();
                for (int r = 0; r < pong_pkg::screen_h; r++)
                        expect_span(0, r, pong_pkg::screen_w, 1'b0, pong_pkg::black);
        endtask

        // the white top line is followed by the right line and then the left line
        task automatic check_borders();
                expect_span(pong_pkg::left_line, pong_pkg::top_line,
                            pong_pkg::right_line - pong_pkg::left_line + 1, 1'b0, pong_pkg::white);
                expect_span(pong_pkg::right_line, pong_pkg::top_line,
                            pong_pkg::screen_h - pong_pkg::top_line, 1'b1, pong_pkg::white);
                expect_span(pong_pkg::left_line, pong_pkg::top_line,
                            pong_pkg::screen_h - pong_pkg::top_line, 1'b1, pong_pkg::white);
        endtask

        // ============================================================
        // game model with positions in 8.4 fixed point held as integers
        // ============================================================

        task automatic model_restart();
                m_pad  = 76;
                m_px   = '{1280, 640};
                m_py   = '{960, 640};
                m_vx   = '{8, -10};
                m_vy   = '{-12, 5};
                m_miss = 0;
        endtask

        // right wins when both keys are held
        task automatic model_paddle();
                if (!keys[0])
                        m_pad = (m_pad + 2 > pad_max) ? pad_max : m_pad + 2;
                else if (!keys[1])
                        m_pad = (m_pad - 2 < pad_min) ? pad_min : m_pad - 2;
        endtask

        task automatic model_puck(input int p);
                int nx, ny, ix;
                nx = m_px[p] + m_vx[p];
                ny = m_py[p] + m_vy[p];
                if (ny / 16 <= pong_pkg::top_line + 1) begin
                        m_vy[p] = -m_vy[p];
                        ny      = (pong_pkg::top_line + 1) * 16;
                end
                ix = nx / 16;
                if (ix <= pong_pkg::left_line + 1 || ix >= pong_pkg::right_line - 1)
                        m_vx[p] = -m_vx[p];
                // the paddle row either sends the puck back up or loses it
                if (ny / 16 >= pong_pkg::paddle_row - 1) begin
                        if (ix >= m_pad && ix <= m_pad + pad_w) begin
                                m_vy[p] = -m_vy[p];
                                ny      = (pong_pkg::paddle_row - 1) * 16;
                        end else begin
                                m_miss = 1;
                        end
                end
                m_px[p] = nx;
                m_py[p] = ny;
        endtask

        // one game pass that returns early with m_miss set when a puck is lost
        task automatic run_pass();
                logic b_right, b_left;
                expect_span(m_pad, pong_pkg::paddle_row, pad_w + 1, 1'b0, pong_pkg::black);
                if (stop == 0 && idle < speed) begin
                        errors++;
                        $display("only %0d idle cycles before the paddle, delay too short", idle);
                end
                model_paddle();
                expect_span(m_pad, pong_pkg::paddle_row, pad_w + 1, 1'b0, pong_pkg::white);
                if (stop == 0 && (first_x < pad_min ||
                                  first_x + pad_w > pong_pkg::right_line - 1)) begin
                        errors++;
                        $display("paddle drawn at x %0d crosses a side line", first_x);
                end
                for (int p = 0; p < 2; p++) begin
                        expect_span(m_px[p] / 16, m_py[p] / 16, 1, 1'b0, pong_pkg::black);
                        model_puck(p);
                        if (m_miss)
                                return;
                        expect_span(m_px[p] / 16, m_py[p] / 16, 1, 1'b0,
                                    p ? pong_pkg::yellow : pong_pkg::cyan);
                end
                // the yellow pixel was seen, so pick the keys for the next pass
                take_bit(b_right);
                take_bit(b_left);
                @(posedge CLOCK_50);
                keys <= {b_left, b_right};
                passes++;
        endtask

        // ============================================================
        // test sequence
        // ============================================================

        initial begin
                int cycles;
                keys      = 2'b11;
                lfsr      = 16'd93;
                errors    = 0;
                stop      = 0;
                passes    = 0;
                test_base = 0;
                tests     = 0;
                failed    = 0;
                cycles    = 0;
                model_restart();
                while (!reset_n && cycles < 100) begin
                        @(posedge CLOCK_50);
                        cycles++;
                end
                if (!reset_n) begin
                        $display("reset was never released");
                        stop = 1;
                end
                check_screen();
                report("clear after reset");
                check_borders();
                report("borders after reset");
                while (passes < 40 && stop == 0 && !m_miss)
                        run_pass();
                report("paddle and pucks over 40 passes");
                // keep playing until the model loses a puck
                while (passes < max_passes && stop == 0 && !m_miss)
                        run_pass();
                if (stop == 0 && !m_miss) begin
                        errors++;
                        $display("no miss was predicted within %0d passes", max_passes);
                end
                report("play until a miss");
                model_restart();
                check_screen();
                check_borders();
                report("clear and borders after a miss");
                run_pass();
                report("paddle and pucks back at their start");
                $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
                if (errors == 0 && stop == 0)
                        $display("*** TEST PASSED ***");
                else
                        $display("*** TEST FAILED ***");
                $finish;
        end

endmodule

/* list.f */
pong_pkg.sv
span_drawer.sv
puck_physics.sv
paddle_ctrl.sv
frame_sequencer.sv
pong_top.sv
tb_clock.sv
tb_pong.sv

/* Makefile */
# Verilator build and run of the pong testbench

VERILATOR ?= verilator
TOP       ?= tb_pong
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qxF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
